// File: rtl/cachePkg.sv
// ----------------------------------------
// Shared types for the data cache; word addressing assumes 4-byte words
// ----------------------------------------
package cachePkg;

    // ----------------------------------------
    // Address and data widths
    // ----------------------------------------

    // Full byte address width of the core and the system bus
    localparam int AddrBits = 32;

    // One data or address word
    typedef logic [AddrBits-1:0] word_t;

    // Byte-lane enables, bit 0 covers bits 7..0
    typedef logic [3:0] byteMask_t;

    // ----------------------------------------
    // Controller states
    // ----------------------------------------

    // Idle also serves every hit without stalling
    typedef enum logic [1:0] {
        Idle,
        WriteBack,
        Refill,
        Finish
    } ctrlState_t;

    // Tag bits left after the byte offset, the block offset and the set index
    // Both arguments are powers of two of at least 2
    function automatic int tagWidth(input int blockWords, input int lines);
        return 30 - $clog2(blockWords) - $clog2(lines);
    endfunction

endpackage

// File: rtl/cacheWayIf.sv
// ----------------------------------------
// Lookup and update signals between the controller and the way arrays
// ----------------------------------------
interface cacheWayIf #(
    parameter int BlockWords = 4,
    parameter int Lines      = 8
);

    localparam int SetBits = $clog2(Lines);
    localparam int TagBits = cachePkg::tagWidth(BlockWords, Lines);

    // Request fields, driven from the core address
    logic [SetBits-1:0] setIdx;
    logic [TagBits-1:0] reqTag;

    // Lookup results
    logic w1Hit;
    logic w2Hit;
    logic victimDirty;
    // Way picked for replacement, 0 is way 1
    logic victimWay;

    // Updates from the FSM
    logic w1We;
    logic w2We;
    logic fillEn;
    logic dirtyIn;
    logic lruUpdate;

    modport mem (
        input  setIdx, reqTag, w1We, w2We, fillEn, dirtyIn, lruUpdate,
        output w1Hit, w2Hit, victimDirty, victimWay
    );

    modport ctrl (
        input  w1Hit, w2Hit, victimDirty, victimWay,
        output w1We, w2We, fillEn, dirtyIn, lruUpdate
    );

endinterface

// File: rtl/cacheMemory.sv
// ----------------------------------------
// Two ways in flops, one LRU bit per set; data and tags have no reset
// ----------------------------------------
module cacheMemory #(
    parameter int BlockWords = 4,
    parameter int Lines      = 8
) (
    input  logic                                               clk,
    input  logic                                               rstN,
    cacheWayIf.mem                                             way,
    input  logic [$clog2(BlockWords)-1:0]                      wordOff,
    input  cachePkg::word_t                                    fillData,
    input  cachePkg::word_t                                    writeData,
    input  cachePkg::byteMask_t                                byteMask,
    output cachePkg::word_t                                    w1Word,
    output cachePkg::word_t                                    w2Word,
    output logic [cachePkg::tagWidth(BlockWords, Lines)-1:0]   victimTag
);

    localparam int TagBits = cachePkg::tagWidth(BlockWords, Lines);

    // ----------------------------------------
    // Storage, first index is the way
    // ----------------------------------------
    logic [TagBits-1:0] tagArr   [2][Lines];
    cachePkg::word_t    dataArr  [2][Lines][BlockWords];
    logic [Lines-1:0]   validArr [2];
    logic [Lines-1:0]   dirtyArr [2];
    // Set bit means way 2 is next to be replaced
    logic [Lines-1:0]   lruBits;

    logic [1:0] wayWe;
    logic [1:0] wayHit;

    // Store merge, untouched lanes keep the old bytes
    function automatic cachePkg::word_t mergeBytes(input cachePkg::word_t oldWord,
                                                   input cachePkg::word_t newWord,
                                                   input cachePkg::byteMask_t mask);
        cachePkg::word_t result;
        result = oldWord;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                result[8*b +: 8] = newWord[8*b +: 8];
            end
        end
        return result;
    endfunction

    assign wayWe = {way.w2We, way.w1We};

    // Tag compare, a line only hits while valid
    assign wayHit[0] = validArr[0][way.setIdx] && (tagArr[0][way.setIdx] == way.reqTag);
    assign wayHit[1] = validArr[1][way.setIdx] && (tagArr[1][way.setIdx] == way.reqTag);
    assign way.w1Hit = wayHit[0];
    assign way.w2Hit = wayHit[1];

    // Victim follows the LRU bit of the set
    assign way.victimWay   = lruBits[way.setIdx];
    assign way.victimDirty = dirtyArr[way.victimWay][way.setIdx];
    assign victimTag       = tagArr[way.victimWay][way.setIdx];

    // Read ports, the word offset comes from the counter during bursts
    assign w1Word = dataArr[0][way.setIdx][wordOff];
    assign w2Word = dataArr[1][way.setIdx][wordOff];

    // ----------------------------------------
    // Data and tag writes
    // ----------------------------------------
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (wayWe[w]) begin
                if (way.fillEn) begin
                    // Whole word from the bus, tag claimed on the first word
                    dataArr[w][way.setIdx][wordOff] <= fillData;
                    tagArr[w][way.setIdx]           <= way.reqTag;
                end else begin
                    dataArr[w][way.setIdx][wordOff] <=
                        mergeBytes(dataArr[w][way.setIdx][wordOff], writeData, byteMask);
                end
            end
        end
    end

    // ----------------------------------------
    // Valid, dirty and LRU state
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rstN) begin
            validArr <= '{default: '0};
            dirtyArr <= '{default: '0};
            lruBits  <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (wayWe[w]) begin
                    validArr[w][way.setIdx] <= 1'b1;
                    // A fresh line is clean, a store marks it dirty
                    dirtyArr[w][way.setIdx] <= way.fillEn ? 1'b0 : way.dirtyIn;
                end
            end
            // Point at the way that did not hit
            if (way.lruUpdate) begin
                lruBits[way.setIdx] <= wayHit[0];
            end
        end
    end

    // A tag lives in at most one way of a set
    assert property (@(posedge clk) disable iff (!rstN) !(way.w1Hit && way.w2Hit));

endmodule

// File: rtl/burstCounter.sv
// ----------------------------------------
// Word counter for one block burst; BlockWords is a power of two of at least 2
// ----------------------------------------
module burstCounter #(
    parameter int BlockWords = 4
) (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          clear,
    input  logic                          advance,
    output logic [$clog2(BlockWords)-1:0] wordOff,
    output logic                          last
);

    localparam int OffBits = $clog2(BlockWords);

    // Final word of the block
    assign last = (wordOff == OffBits'(BlockWords - 1));

    // Clear wins over advance
    // Holds while the bus stalls
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wordOff <= '0;
        end else if (clear) begin
            wordOff <= '0;
        end else if (advance) begin
            // Wrap so a write-back flows straight into the refill
            wordOff <= last ? '0 : wordOff + 1'b1;
        end
    end

endmodule

// File: rtl/cacheController.sv
// ----------------------------------------
// Miss FSM; the core must hold its request while Stall is high
// ----------------------------------------
module cacheController #(
    parameter int BlockWords = 4,
    parameter int Lines      = 8
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    MemWrite,
    input  logic    MemRead,
    input  logic    BusReady,
    cacheWayIf.ctrl way,
    input  logic    last,
    output logic    clear,
    output logic    advance,
    output logic    useBus,
    output logic    Stall,
    output logic    HRequest,
    output logic    HWrite
);

    cachePkg::ctrlState_t state;
    cachePkg::ctrlState_t nextState;

    logic access;
    logic hit;
    logic accepted;
    logic storeHit;
    logic fillWord;

    // Field slicing in the top needs at least one offset and one set bit
    if (BlockWords < 2 || Lines < 2) begin : gParamCheck
        $error("cacheController needs BlockWords and Lines of at least 2");
    end

    assign access   = MemRead | MemWrite;
    assign hit      = way.w1Hit | way.w2Hit;
    // One word moves per cycle with both request and ready
    assign accepted = HRequest & BusReady;

    // ----------------------------------------
    // State register and next state
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= cachePkg::Idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        unique case (state)
            cachePkg::Idle: begin
                // Dirty victim goes out before the new block comes in
                if (access && !hit) begin
                    nextState = way.victimDirty ? cachePkg::WriteBack : cachePkg::Refill;
                end
            end
            cachePkg::WriteBack: begin
                if (accepted && last) begin
                    nextState = cachePkg::Refill;
                end
            end
            cachePkg::Refill: begin
                if (accepted && last) begin
                    nextState = cachePkg::Finish;
                end
            end
            cachePkg::Finish: begin
                nextState = cachePkg::Idle;
            end
            default: begin
                nextState = cachePkg::Idle;
            end
        endcase
    end

    // ----------------------------------------
    // Bus and core outputs
    // ----------------------------------------
    assign useBus   = (state == cachePkg::WriteBack) || (state == cachePkg::Refill);
    assign HRequest = useBus;
    assign HWrite   = (state == cachePkg::WriteBack);
    // Counter sits at word 0 outside bursts
    assign clear    = !useBus;
    assign advance  = accepted;
    // Hit in Idle completes at once, anything else stalls
    assign Stall    = (state != cachePkg::Idle) || (access && !hit);

    // ----------------------------------------
    // Way updates
    // ----------------------------------------
    assign storeHit = (state == cachePkg::Idle) && MemWrite && hit;
    assign fillWord = (state == cachePkg::Refill) && BusReady;

    // Store goes to the hitting way, fill to the victim
    assign way.w1We      = (storeHit && way.w1Hit) || (fillWord && !way.victimWay);
    assign way.w2We      = (storeHit && way.w2Hit) || (fillWord && way.victimWay);
    assign way.fillEn    = (state == cachePkg::Refill);
    assign way.dirtyIn   = MemWrite;
    assign way.lruUpdate = (state == cachePkg::Idle) && access && hit;

    // Bus writes only drain a dirty victim while the request still misses
    assert property (@(posedge clk) disable iff (!rstN)
        HWrite |-> way.victimDirty && !hit);

endmodule

// File: rtl/dataCache.sv
// ----------------------------------------
// Two-way write-back data cache; no uncached space and no bus errors
// ----------------------------------------
module dataCache #(
    parameter int BlockWords = 4,
    parameter int Lines      = 8
) (
    input  logic                clk,
    input  logic                rstN,
    // Core side
    input  logic                MemWrite,
    input  logic                MemRead,
    input  cachePkg::word_t     A,
    input  cachePkg::word_t     WD,
    input  cachePkg::byteMask_t ByteMask,
    output cachePkg::word_t     RD,
    output logic                Stall,
    // Bus side
    output logic                HRequest,
    output logic                HWrite,
    output cachePkg::word_t     HAddr,
    output cachePkg::word_t     HWData,
    input  cachePkg::word_t     HRData,
    input  logic                BusReady
);

    localparam int AddrBits = cachePkg::AddrBits;
    localparam int SetBits  = $clog2(Lines);
    localparam int OffBits  = $clog2(BlockWords);
    localparam int TagBits  = cachePkg::tagWidth(BlockWords, Lines);

    logic [OffBits-1:0] cntOff;
    logic [OffBits-1:0] wordOff;
    logic [TagBits-1:0] victimTag;
    logic               cntClear;
    logic               cntAdvance;
    logic               cntLast;
    logic               useBus;
    logic               rdFromBus;
    cachePkg::word_t    burstAddr;
    cachePkg::word_t    victimAddr;
    cachePkg::word_t    w1Word;
    cachePkg::word_t    w2Word;

    cacheWayIf #(.BlockWords(BlockWords), .Lines(Lines)) wayIf ();

    // ----------------------------------------
    // Address fields
    // ----------------------------------------
    assign wayIf.setIdx = A[OffBits+2 +: SetBits];
    assign wayIf.reqTag = A[AddrBits-1 -: TagBits];

    // Counter replaces the word offset while a burst runs
    assign wordOff   = useBus ? cntOff : A[2 +: OffBits];
    assign burstAddr = {A[AddrBits-1:OffBits+2], wordOff, 2'b00};
    // Write-back goes to where the victim came from
    assign victimAddr = {victimTag, burstAddr[AddrBits-TagBits-1:0]};
    assign HAddr      = HWrite ? victimAddr : burstAddr;

    // ----------------------------------------
    // Data selection
    // ----------------------------------------
    assign rdFromBus = useBus && !HWrite;

    // Victim word leaves on write-back
    assign HWData = wayIf.victimWay ? w2Word : w1Word;
    // Bus word passes through during refill
    assign RD     = rdFromBus ? HRData : (wayIf.w2Hit ? w2Word : w1Word);

    // ----------------------------------------
    // Blocks
    // ----------------------------------------
    // Fills take the bus word, store hits merge the core word
    cacheMemory #(.BlockWords(BlockWords), .Lines(Lines)) mem_i (
        .clk       (clk),
        .rstN      (rstN),
        .way       (wayIf.mem),
        .wordOff   (wordOff),
        .fillData  (HRData),
        .writeData (WD),
        .byteMask  (ByteMask),
        .w1Word    (w1Word),
        .w2Word    (w2Word),
        .victimTag (victimTag)
    );

    burstCounter #(.BlockWords(BlockWords)) counter_i (
        .clk     (clk),
        .rstN    (rstN),
        .clear   (cntClear),
        .advance (cntAdvance),
        .wordOff (cntOff),
        .last    (cntLast)
    );

    cacheController #(.BlockWords(BlockWords), .Lines(Lines)) ctrl_i (
        .clk      (clk),
        .rstN     (rstN),
        .MemWrite (MemWrite),
        .MemRead  (MemRead),
        .BusReady (BusReady),
        .way      (wayIf.ctrl),
        .last     (cntLast),
        .clear    (cntClear),
        .advance  (cntAdvance),
        .useBus   (useBus),
        .Stall    (Stall),
        .HRequest (HRequest),
        .HWrite   (HWrite)
    );

endmodule

// File: verification/tbClock.sv
// ----------------------------------------
// Free-running clock that starts low
// ----------------------------------------
module tbClock #(
    parameter int Period = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // Half a period low, half high
    always begin
        #(Period / 2);
        clk = ~clk;
    end

endmodule

// File: verification/busMemory.sv
// ----------------------------------------
// Word bus slave; addresses wrap at Words, BusReady comes from an LCG
// ----------------------------------------
module busMemory #(
    parameter int Words      = 1024,
    parameter int Seed       = 81705,
    parameter int DriveDelay = 2
) (
    input  logic            clk,
    input  logic            HRequest,
    input  logic            HWrite,
    input  cachePkg::word_t HAddr,
    input  cachePkg::word_t HWData,
    output cachePkg::word_t HRData,
    output logic            BusReady
);

    localparam int IdxBits = $clog2(Words);

    cachePkg::word_t    mem [Words];
    logic [31:0]        lcgState;
    logic [IdxBits-1:0] idx;

    // 16 upper bits of the next LCG state
    function automatic logic [31:0] stepLcg();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return {16'd0, lcgState[31:16]};
    endfunction

    initial begin
        lcgState = 32'(Seed);
        BusReady = 1'b0;
        for (int i = 0; i < Words; i++) begin
            // Both halves carry the index so a slipped address shows up
            mem[i] = {~16'(i), 16'(i)} ^ 32'h5A5A_0000;
        end
    end

    assign idx    = HAddr[IdxBits+1:2];
    // Zero outside a request, also before reset settles
    assign HRData = (HRequest === 1'b1) ? mem[idx] : '0;

    // One word per cycle with request and ready
    always @(posedge clk) begin
        if (HRequest && HWrite && BusReady) begin
            mem[idx] = HWData;
        end
    end

    // Back-pressure, roughly three ready cycles in four
    always @(posedge clk) begin
        logic [31:0] r;
        #DriveDelay;
        r        = stepLcg();
        BusReady = (r[1:0] != 2'b00);
    end

endmodule

// File: verification/dataCacheTb.sv
// ----------------------------------------
// Directed and random accesses checked against a flat shadow memory
// Directed addresses assume 4-word blocks and 8 sets
// ----------------------------------------
module dataCacheTb;

    localparam int BlockWords  = 4;
    localparam int Lines       = 8;
    localparam int DriveDelay  = 2;
    localparam int ResetCycles = 16;
    localparam int RandomOps   = 400;
    // About 50 directed accesses plus the random mix
    // Each gets a write-back and a refill at a quarter of the bus rate
    localparam int MaxCycles   = ResetCycles + (RandomOps + 60) * (8 * BlockWords + 6);

    logic                clk;
    logic                rstN;
    logic                MemWrite;
    logic                MemRead;
    cachePkg::word_t     A;
    cachePkg::word_t     WD;
    cachePkg::byteMask_t ByteMask;
    cachePkg::word_t     RD;
    logic                Stall;
    logic                HRequest;
    logic                HWrite;
    cachePkg::word_t     HAddr;
    cachePkg::word_t     HWData;
    cachePkg::word_t     HRData;
    logic                BusReady;

    // Reference memory and check bookkeeping
    cachePkg::word_t shadow [1024];
    cachePkg::word_t wbAddr [$];
    cachePkg::word_t wbData [$];
    cachePkg::word_t expWord;
    string           curTest;
    logic            loadPending;
    logic [31:0]     rngState;
    int              errorCount;
    int              checkCount;
    int              cycleCount = 0;

    tbClock #(.Period(40)) clk_i (.clk(clk));

    dataCache #(.BlockWords(BlockWords), .Lines(Lines)) dut_i (
        .clk(clk), .rstN(rstN), .MemWrite(MemWrite), .MemRead(MemRead),
        .A(A), .WD(WD), .ByteMask(ByteMask), .RD(RD), .Stall(Stall),
        .HRequest(HRequest), .HWrite(HWrite), .HAddr(HAddr), .HWData(HWData),
        .HRData(HRData), .BusReady(BusReady)
    );

    busMemory #(.Words(1024), .Seed(81705), .DriveDelay(DriveDelay)) busMem_i (
        .clk(clk), .HRequest(HRequest), .HWrite(HWrite), .HAddr(HAddr),
        .HWData(HWData), .HRData(HRData), .BusReady(BusReady)
    );

    // ----------------------------------------
    // Reference model and stimulus helpers
    // ----------------------------------------
    function automatic logic [31:0] nextRandom();
        rngState = rngState * 32'd1103515245 + 32'd12345;
        return {16'd0, rngState[31:16]};
    endfunction

    // Applies a store to the shadow, returns the word a load sees afterwards
    function automatic cachePkg::word_t modelAccess(input logic write,
                                                    input cachePkg::word_t addr,
                                                    input cachePkg::word_t data,
                                                    input cachePkg::byteMask_t mask);
        if (write) begin
            for (int b = 0; b < 4; b++) begin
                if (mask[b]) begin
                    shadow[addr[11:2]][8*b +: 8] = data[8*b +: 8];
                end
            end
        end
        return shadow[addr[11:2]];
    endfunction

    // Holds one request until the first edge with Stall low
    task automatic runAccess(input string name, input logic write, input cachePkg::word_t addr,
                             input cachePkg::word_t data, input cachePkg::byteMask_t mask,
                             output int cycles, output logic sawBus);
        @(posedge clk);
        #DriveDelay;
        curTest     = name;
        expWord     = modelAccess(write, addr, data, mask);
        A           = addr;
        WD          = data;
        ByteMask    = mask;
        MemWrite    = write;
        MemRead     = !write;
        loadPending = !write;
        cycles      = 0;
        sawBus      = 1'b0;
        do begin
            @(posedge clk);
            cycles++;
            if (HRequest) begin
                sawBus = 1'b1;
            end
        end while (Stall);
        #DriveDelay;
        MemWrite    = 1'b0;
        MemRead     = 1'b0;
        loadPending = 1'b0;
    endtask

    task automatic loadWord(input string name, input cachePkg::word_t addr);
        int   cycles;
        logic sawBus;
        runAccess(name, 1'b0, addr, '0, 4'hF, cycles, sawBus);
    endtask

    task automatic storeWord(input string name, input cachePkg::word_t addr,
                             input cachePkg::word_t data, input cachePkg::byteMask_t mask);
        int   cycles;
        logic sawBus;
        runAccess(name, 1'b1, addr, data, mask, cycles, sawBus);
    endtask

    task automatic printSummary();
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    endtask

    // ----------------------------------------
    // Monitors
    // ----------------------------------------
    // Load result at completion
    always @(posedge clk) begin
        if (loadPending && !Stall) begin
            checkCount++;
            if (RD !== expWord) begin
                errorCount++;
                $display("[FAIL] %s: expected %h, actual %h", curTest, expWord, RD);
            end
        end
    end

    // Accepted bus writes
    always @(posedge clk) begin
        if (HRequest && HWrite && BusReady) begin
            wbAddr.push_back(HAddr);
            wbData.push_back(HWData);
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > MaxCycles) begin
            $display("Timeout after %0d cycles, a request never completed", MaxCycles);
            printSummary();
            $display("Result: FAILED");
            $finish;
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        int              cycles;
        logic            sawBus;
        logic [31:0]     r;
        logic [31:0]     hi;
        logic [31:0]     lo;
        cachePkg::word_t addr;
        rstN        = 1'b0;
        MemWrite    = 1'b0;
        MemRead     = 1'b0;
        A           = '0;
        WD          = '0;
        ByteMask    = '0;
        loadPending = 1'b0;
        expWord     = '0;
        curTest     = "reset";
        errorCount  = 0;
        checkCount  = 0;
        rngState    = 32'd81705;
        repeat (ResetCycles) @(posedge clk);
        #DriveDelay;
        rstN = 1'b1;
        for (int i = 0; i < 1024; i++) begin
            shadow[i] = busMem_i.mem[i];
        end

        // Cold miss, then a hit in the same block
        runAccess("cold miss", 1'b0, 32'h004, '0, 4'hF, cycles, sawBus);
        checkCount++;
        if (!sawBus) begin
            errorCount++;
            $display("Cold miss completed without any bus request");
        end
        runAccess("same block hit", 1'b0, 32'h008, '0, 4'hF, cycles, sawBus);
        checkCount++;
        if (cycles != 1) begin
            errorCount++;
            $display("[FAIL] same block hit cycles: expected 1, actual %0d", cycles);
        end
        checkCount++;
        if (sawBus) begin
            errorCount++;
            $display("Hit in a resident block raised a bus request");
        end

        // Every byte mask on a resident word, set 1
        loadWord("mask setup", 32'h098);
        for (int m = 0; m < 16; m++) begin
            storeWord("masked store", 32'h098, 32'h9E3779B9 * 32'(m + 1), m[3:0]);
            loadWord($sformatf("mask %h load", m), 32'h098);
        end

        // Dirty line in set 2 pushed out by two other tags
        storeWord("evict store", 32'h0A4, 32'hDEADBEEF, 4'hF);
        loadWord("evict second tag", 32'h120);
        wbAddr.delete();
        wbData.delete();
        loadWord("evict third tag", 32'h1A0);
        checkCount++;
        if (wbAddr.size() != BlockWords) begin
            errorCount++;
            $display("[FAIL] write-back words: expected %0d, actual %0d",
                     BlockWords, wbAddr.size());
        end else begin
            for (int i = 0; i < BlockWords; i++) begin
                addr = 32'h0A0 + 32'(4 * i);
                checkCount++;
                if (wbAddr[i] !== addr || wbData[i] !== shadow[addr[11:2]]) begin
                    errorCount++;
                    $display("[FAIL] write-back word %0d: expected %h at %h, actual %h at %h",
                             i, shadow[addr[11:2]], addr, wbData[i], wbAddr[i]);
                end
            end
        end
        loadWord("evict reload", 32'h0A4);

        // LRU in set 3, X touched last before Z arrives
        loadWord("lru X", 32'h0B0);
        loadWord("lru Y", 32'h130);
        loadWord("lru X again", 32'h0B0);
        loadWord("lru Z", 32'h1B0);
        runAccess("lru reload X", 1'b0, 32'h0B4, '0, 4'hF, cycles, sawBus);
        checkCount++;
        if (sawBus) begin
            errorCount++;
            $display("Recently used line X was evicted, reload went to the bus");
        end
        runAccess("lru reload Y", 1'b0, 32'h134, '0, 4'hF, cycles, sawBus);
        checkCount++;
        if (!sawBus) begin
            errorCount++;
            $display("Least recently used line Y was kept instead of replaced");
        end

        // Random mix over 256 words
        for (int n = 0; n < RandomOps; n++) begin
            r    = nextRandom();
            hi   = nextRandom();
            lo   = nextRandom();
            addr = {22'd0, r[7:0], 2'b00};
            if (r[8]) begin
                storeWord("random store", addr, {hi[15:0], lo[15:0]}, r[12:9]);
            end else begin
                loadWord($sformatf("random load %0d", n), addr);
            end
        end

        repeat (2) @(posedge clk);
        printSummary();
        if (errorCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
rtl/cachePkg.sv
rtl/cacheWayIf.sv
rtl/cacheMemory.sv
rtl/burstCounter.sv
rtl/cacheController.sv
rtl/dataCache.sv
verification/tbClock.sv
verification/busMemory.sv
verification/dataCacheTb.sv

// File: run.sh
#!/bin/sh
# Build the cache testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module dataCacheTb -f verilog.f -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Result: PASSED$"; then
    exit 0
fi
exit 1
